/* Makefile */
VERILATOR ?= verilator
TOP       ?= nes_dma_tb
FILELIST  ?= nes_dma.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory $(OBJ_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/nes_dma_checker.sv */
// Bus protocol assertions, bound into nes_dma_top.
// dmc_ack is compared across CPU cycles, sampled where cpu_ce is high.
`timescale 1ns/1ns
`default_nettype none

module nes_dma_checker (
	input logic                           clk,
	input logic                           reset,
	input logic                           cpu_ce,
	input logic                           dmc_ack,
	input logic                           mem_read,
	input logic                           mem_write,
	input logic [nes_dma_pkg::addr_w-1:0] mem_addr,
	input logic [nes_dma_pkg::addr_w-1:0] dmc_addr
);

	logic ack_last;       // dmc_ack of the previous CPU cycle
	int   fail_count = 0; // Number of failed assertions

	always_ff @(posedge clk) begin
		if (reset)
			ack_last <= 1'b0;
		else if (cpu_ce)
			ack_last <= dmc_ack;
	end

	// One direction at a time
	rw_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(mem_read && mem_write))
		else begin
			fail_count++;
			$error("mem_read and mem_write high together");
		end

	ack_on_dmc_addr: assert property (@(posedge clk) disable iff (reset)
		dmc_ack |-> (mem_read && mem_addr == dmc_addr))
		else begin
			fail_count++;
			$error("dmc_ack without a read of dmc_addr");
		end

	ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
		(cpu_ce && ack_last) |-> !dmc_ack)
		else begin
			fail_count++;
			$error("dmc_ack high for two CPU cycles in a row");
		end

endmodule

bind nes_dma_top nes_dma_checker checker0 (
	.clk       (clk),
	.reset     (reset),
	.cpu_ce    (cpu_ce),
	.dmc_ack   (dmc_ack),
	.mem_read  (mem_read),
	.mem_write (mem_write),
	.mem_addr  (mem_addr),
	.dmc_addr  (dmc_addr)
);

`default_nettype wire

/* dv/nes_dma_tb.sv */
// Directed testbench for the OAM and DMC DMA path.
// Memory is a read-only 64 KB model. PPU and APU return fixed bytes.
// Outputs are sampled on the clock where cpu_ce is high.
// Between accesses the CPU parks on a PPU read.
`timescale 1ns/1ns
`default_nettype none

module nes_dma_tb;

	localparam int div_cpu  = nes_dma_pkg::div_cpu_default;
	localparam int wait_max = 2000; // CPU cycles before a sprite transfer counts as stalled
	localparam logic [7:0]  ppu_byte  = 8'hc3;
	localparam logic [7:0]  apu_byte  = 8'h5e;
	localparam logic [15:0] park_addr = 16'h2002; // PPU read keeps the memory port quiet

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic [15:0] cpu_addr;
	logic        cpu_rnw;
	logic [7:0]  cpu_dout;
	logic        dmc_request;
	logic [15:0] dmc_addr;
	logic [7:0]  mem_din;
	logic [7:0]  ppu_din;
	logic [7:0]  apu_din;
	logic        cpu_ce;
	logic [7:0]  cpu_din;
	logic        pause_cpu;
	logic        dmc_ack;
	logic [15:0] mem_addr;
	logic        mem_read;
	logic        mem_write;
	logic [7:0]  mem_wdata;

	logic [7:0]  mem [0:65535]; // Memory model contents
	logic [31:0] lcg;
	int          errors = 0;
	int          test_errs = 0; // Errors in the test now running
	int          checks = 0;
	int          tests = 0;
	bit          timed_out = 1'b0;

	nes_dma_top #(.DIV_CPU(div_cpu)) dut0 (.*);

	assign mem_din = mem[mem_addr]; // Asynchronous read

	always #5 clk = ~clk; // 10 ns period

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic log_error(input string msg);
		errors++;
		test_errs++;
		$display("** Error at %0t ns: %s", $time, msg);
	endtask

	task automatic check(input bit ok, input string msg);
		checks++;
		assert (ok) else log_error(msg);
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %-20s done, %0d errors", name, test_errs);
		test_errs = 0;
	endtask

	// Advance to the next clock with cpu_ce high
	// Values seen there are those of the ending cycle
	task automatic next_ce();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!cpu_ce && n < 2 * div_cpu);
		if (!cpu_ce) begin
			if (!timed_out)
				$display("Timeout: cpu_ce did not pulse within %0d clocks", n);
			timed_out = 1'b1;
		end
	endtask

	task automatic cpu_drive(input logic [15:0] addr, input logic rnw, input logic [7:0] dout);
		cpu_addr <= addr;
		cpu_rnw  <= rnw;
		cpu_dout <= dout;
		next_ce(); // One CPU cycle on the bus
	endtask

	task automatic reset_state();
		int gap;
		next_ce();
		gap = 0;
		do begin
			@(posedge clk);
			gap++;
		end while (!cpu_ce && gap < 2 * div_cpu);
		check(gap == div_cpu,
			$sformatf("cpu_ce period %0d clocks, expected %0d", gap, div_cpu));
		check(!pause_cpu && !dmc_ack, "pause_cpu or dmc_ack high after reset");
		check(!mem_read && !mem_write, "memory strobes active after reset");
		finish_test("reset");
	endtask

	task automatic cpu_passthrough();
		cpu_drive(16'h0345, 1'b1, 8'h00);
		check(mem_addr == 16'h0345 && mem_read && !mem_write, "CPU read not on the memory port");
		check(cpu_din == mem[16'h0345], $sformatf("CPU read data %h", cpu_din));
		cpu_drive(16'h0123, 1'b0, 8'h5a);
		check(mem_addr == 16'h0123 && mem_write && !mem_read, "CPU write not on the memory port");
		check(mem_wdata == 8'h5a, $sformatf("CPU write data %h, expected 5a", mem_wdata));
		cpu_drive(park_addr, 1'b1, 8'h00);
		finish_test("passthrough");
	endtask

	task automatic region_reads();
		cpu_drive(park_addr, 1'b1, 8'h00);
		check(cpu_din == ppu_byte && !mem_read, $sformatf("PPU window read %h", cpu_din));
		cpu_drive(nes_dma_pkg::apu_status_addr, 1'b1, 8'h00);
		check(cpu_din == apu_byte, $sformatf("APU status read %h", cpu_din));
		cpu_drive(16'h0456, 1'b1, 8'h00);
		check(cpu_din == mem[16'h0456], $sformatf("memory read %h", cpu_din));
		cpu_drive(16'h4016, 1'b1, 8'h00); // Write-only register floats to the last bus value
		check(cpu_din == mem[16'h0456], $sformatf("open bus read %h", cpu_din));
		cpu_drive(16'h8123, 1'b1, 8'h00);
		check(cpu_din == mem[16'h8123], $sformatf("upper memory read %h", cpu_din));
		cpu_drive(park_addr, 1'b1, 8'h00);
		finish_test("regions");
	endtask

	task automatic dmc_idle_access();
		int n;
		dmc_addr    <= 16'hc0a5;
		dmc_request <= 1'b1;
		n = 0;
		do begin
			next_ce();
			n++;
		end while (!dmc_ack && n < 8 && !timed_out);
		check(dmc_ack, "no dmc_ack within 8 CPU cycles");
		check(mem_addr == 16'hc0a5 && mem_read, $sformatf("DMC access at %h", mem_addr));
		check(cpu_din == mem[16'hc0a5], $sformatf("DMC byte %h", cpu_din));
		dmc_request <= 1'b0; // APU lets go after the ack
		next_ce();
		check(!dmc_ack && !pause_cpu, "DMC did not release the bus");
		finish_test("dmc_idle");
	endtask

	// Sprite DMA from page, with a DMC request raised every dmc_every cycles when nonzero
	task automatic sprite_transfer(input logic [7:0] page, input int dmc_every, input string name);
		logic [7:0] got [$];
		int cyc;
		int asks;
		int acks;
		int pause_low;
		cyc = 0;
		asks = 0;
		acks = 0;
		pause_low = 0;
		cpu_drive(nes_dma_pkg::oam_dma_addr, 1'b0, page); // Trigger taken on this cpu_ce
		cpu_addr <= park_addr;
		cpu_rnw  <= 1'b1;
		while (got.size() < 256 && cyc < wait_max && !timed_out) begin
			next_ce();
			cyc++;
			if (!pause_cpu)
				pause_low++;
			if (dmc_ack) begin
				check(mem_addr == dmc_addr && cpu_din == mem[dmc_addr],
					$sformatf("DMC read of %h returned %h", mem_addr, cpu_din));
				acks++;
				dmc_request <= 1'b0;
			end else if (mem_write) begin
				check(mem_addr == nes_dma_pkg::oam_data_addr,
					$sformatf("DMA write went to %h", mem_addr));
				got.push_back(mem_wdata);
			end
			if (dmc_every > 0 && cyc % dmc_every == 0 && !dmc_request) begin
				dmc_addr    <= 16'hc100 + 16'(cyc);
				dmc_request <= 1'b1;
				asks++;
			end
		end
		if (got.size() != 256) begin
			$display("Timeout: sprite DMA stalled after %0d OAM writes", got.size());
			timed_out = 1'b1;
		end
		for (int k = 0; k < got.size(); k++)
			check(got[k] == mem[{page, 8'(k)}], $sformatf("OAM byte %0d is %h", k, got[k]));
		check(pause_low == 0, $sformatf("pause_cpu low in %0d transfer cycles", pause_low));
		check(acks == asks, $sformatf("%0d DMC acks for %0d requests", acks, asks));
		next_ce();
		check(!pause_cpu, "pause_cpu still high after the last OAM write");
		finish_test(name);
	endtask

	initial begin
		lcg = 32'h2b66;
		for (int a = 0; a < 65536; a++) begin
			lcg = lcg_next(lcg);
			mem[a] = lcg[23:16] ^ 8'(a) ^ 8'(a >> 8); // Mixed with both address bytes
		end
		cpu_addr    = park_addr;
		cpu_rnw     = 1'b1;
		cpu_dout    = 8'h00;
		dmc_request = 1'b0;
		dmc_addr    = 16'h0000;
		ppu_din     = ppu_byte;
		apu_din     = apu_byte;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		reset_state();
		cpu_passthrough();
		region_reads();
		sprite_transfer(8'h37, 0, "sprite_dma");
		dmc_idle_access();
		sprite_transfer(8'hd2, 97, "sprite_dma_with_dmc");
		errors += dut0.checker0.fail_count; // Failed bus protocol assertions
		$display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0 && !timed_out)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/bus_arbiter.sv */
// Bus owner mux between CPU and DMA, plus the read data path.
// CPU reads strobe mem_read only outside the PPU and APU windows.
// DMA reads always take memory data, the selects follow the CPU address.
// Read data is forced to zero during reset.
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [nes_dma_pkg::addr_w-1:0] cpu_addr,
	input  logic                           cpu_rnw,
	input  logic [nes_dma_pkg::data_w-1:0] cpu_dout,
	input  logic                           dma_own,
	input  logic [nes_dma_pkg::addr_w-1:0] dma_addr,
	input  logic                           dma_read,
	input  logic [nes_dma_pkg::data_w-1:0] dma_data,
	input  logic                           ppu_sel,
	input  logic                           apu_sel,
	input  logic                           status_sel,
	input  logic [nes_dma_pkg::data_w-1:0] mem_din,
	input  logic [nes_dma_pkg::data_w-1:0] ppu_din,
	input  logic [nes_dma_pkg::data_w-1:0] apu_din,
	output logic [nes_dma_pkg::addr_w-1:0] mem_addr,
	output logic                           mem_read,
	output logic                           mem_write,
	output logic [nes_dma_pkg::data_w-1:0] mem_wdata,
	output logic [nes_dma_pkg::data_w-1:0] mem_rdata,
	output logic [nes_dma_pkg::data_w-1:0] cpu_din
);

	logic [nes_dma_pkg::data_w-1:0] rdata;    // Current bus value
	logic [nes_dma_pkg::data_w-1:0] open_bus; // Bus value one clock ago
	logic                           cpu_mem;  // CPU address is in memory space

	assign cpu_mem = !ppu_sel && !apu_sel;

	assign mem_addr  = dma_own ? dma_addr  : cpu_addr;
	assign mem_wdata = dma_own ? dma_data  : cpu_dout;
	assign mem_read  = dma_own ? dma_read  : (cpu_rnw && cpu_mem);
	assign mem_write = dma_own ? !dma_read : !cpu_rnw;

	always_comb begin
		if (reset)
			rdata = '0;
		else if (dma_own)
			rdata = mem_din;  // DMA sources live in memory
		else if (ppu_sel)
			rdata = ppu_din;
		else if (status_sel)
			rdata = apu_din;
		else if (apu_sel)
			rdata = open_bus; // Write-only APU/IO registers float
		else
			rdata = mem_din;
	end

	always_ff @(posedge clk) begin
		open_bus <= rdata;
	end

	assign mem_rdata = rdata; // Back to the sprite byte latch
	assign cpu_din   = rdata;

endmodule

`default_nettype wire

/* hw/cpu_bus_decode.sv */
// Decodes the CPU address into PPU, APU and status selects.
// The trigger is the CPU write to the sprite DMA register on its cpu_ce.
// sprite_page holds the last byte written there, valid from the next clock.
`timescale 1ns/1ns
`default_nettype none

module cpu_bus_decode (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           cpu_ce,
	input  logic [nes_dma_pkg::addr_w-1:0] cpu_addr,
	input  logic                           cpu_rnw,
	input  logic [nes_dma_pkg::data_w-1:0] cpu_dout,
	output logic                           sprite_trigger,
	output logic [nes_dma_pkg::data_w-1:0] sprite_page,
	output logic                           ppu_sel,
	output logic                           apu_sel,
	output logic                           status_sel
);

	nes_dma_pkg::bus_addr_u addr_v; // CPU address
	nes_dma_pkg::bus_addr_u src_q;  // Captured DMA source, offset always zero

	assign addr_v.flat = cpu_addr;

	// Region windows
	assign ppu_sel    = (addr_v.flat >= nes_dma_pkg::ppu_base) &&
	                    (addr_v.flat <  nes_dma_pkg::ppu_end);
	assign apu_sel    = (addr_v.flat >= nes_dma_pkg::apu_base) &&
	                    (addr_v.flat <  nes_dma_pkg::apu_end);
	assign status_sel = (addr_v.flat == nes_dma_pkg::apu_status_addr);

	assign sprite_trigger = cpu_ce && !cpu_rnw && (addr_v.flat == nes_dma_pkg::oam_dma_addr);

	always_ff @(posedge clk) begin
		if (reset) begin
			src_q.flat <= '0;
		end else if (sprite_trigger) begin
			src_q.po.page   <= cpu_dout; // Written byte is the source page
			src_q.po.offset <= '0;
		end
	end

	assign sprite_page = src_q.po.page;

endmodule

`default_nettype wire

/* hw/cpu_cycle_gen.sv */
// CPU clock enable, one clk out of every DIV_CPU, DIV_CPU must be 2 or more.
// odd_cycle is the parity of the CPU cycle in progress, odd right after reset.
`timescale 1ns/1ns
`default_nettype none

module cpu_cycle_gen #(
	parameter int DIV_CPU = nes_dma_pkg::div_cpu_default
) (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,
	output logic odd_cycle
);

	localparam int CNT_W = $clog2(DIV_CPU);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIV_CPU - 1);

	logic [CNT_W-1:0] div_cnt; // Position inside the CPU cycle

	assign cpu_ce = (div_cnt == CNT_LAST); // Last clock of the CPU cycle

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
		end else if (cpu_ce) begin
			div_cnt <= '0; // Wrap
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Parity flips at the end of every CPU cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			odd_cycle <= 1'b1; // First cycle counts as odd
		end else if (cpu_ce) begin
			odd_cycle <= ~odd_cycle;
		end
	end

endmodule

`default_nettype wire

/* hw/dma_sequencer.sv */
// Sprite and DMC DMA sequencer, all state moves on cpu_ce.
// Sprite reads happen on even cycles and OAM writes on odd cycles.
// A DMC access steals an even cycle, the sprite pair then restarts on its read.
// The CPU must hold still while pause_cpu is high.
`timescale 1ns/1ns
`default_nettype none

module dma_sequencer (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           cpu_ce,
	input  logic                           odd_cycle,
	input  logic                           cpu_rnw,
	input  logic                           sprite_trigger,
	input  logic [nes_dma_pkg::data_w-1:0] sprite_page,
	input  logic                           dmc_request,
	input  logic [nes_dma_pkg::addr_w-1:0] dmc_addr,
	input  logic [nes_dma_pkg::data_w-1:0] mem_rdata,
	output logic                           dma_own,
	output logic [nes_dma_pkg::addr_w-1:0] dma_addr,
	output logic                           dma_read,
	output logic [nes_dma_pkg::data_w-1:0] dma_data,
	output logic                           dmc_ack,
	output logic                           pause_cpu
);

	// Bit 0 pauses the CPU, bit 1 owns the bus
	localparam logic [1:0] SPR_IDLE   = 2'b00;
	localparam logic [1:0] SPR_PEND   = 2'b01;
	localparam logic [1:0] SPR_ACTIVE = 2'b11;

	logic [1:0]                     spr_state;
	logic                           dmc_state; // DMC access booked for the next even cycle
	nes_dma_pkg::bus_addr_u         src_ptr;   // Sprite source page:offset
	logic [nes_dma_pkg::data_w-1:0] byte_q;    // Sprite byte between read and write
	logic                           spr_go;    // Pending transfer starts next cycle

	assign spr_go = (spr_state == SPR_PEND) && cpu_rnw && odd_cycle;

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= SPR_IDLE;
			dmc_state <= 1'b0;
		end else if (cpu_ce) begin
			// DMC books on an even CPU read cycle, runs on the next even one
			if (!dmc_state && dmc_request && cpu_rnw && !odd_cycle)
				dmc_state <= 1'b1;
			else if (dmc_state && !odd_cycle)
				dmc_state <= 1'b0;

			if (sprite_trigger) begin
				spr_state <= SPR_PEND;
			end else begin
				case (spr_state)
					SPR_PEND: if (spr_go) spr_state <= SPR_ACTIVE;
					SPR_ACTIVE: begin
						if (!odd_cycle && dmc_state)
							spr_state <= SPR_PEND; // DMC took the read slot
						else if (odd_cycle && src_ptr.po.offset == '1)
							spr_state <= SPR_IDLE; // Write of offset FF done
					end
					default: spr_state <= SPR_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (spr_go)
				src_ptr.po.page <= sprite_page;
			if (spr_state == SPR_ACTIVE && odd_cycle)
				src_ptr.po.offset <= src_ptr.po.offset + 1'b1; // Step after each write
			if (spr_state == SPR_ACTIVE && !odd_cycle && !dmc_ack)
				byte_q <= mem_rdata;
			if (sprite_trigger)
				src_ptr.po.offset <= '0;
		end
	end

	assign dmc_ack   = dmc_state && !odd_cycle;
	assign dma_own   = dmc_ack || spr_state[1];
	assign dma_read  = !odd_cycle; // Even reads, odd writes
	assign dma_data  = byte_q;
	assign pause_cpu = spr_state[0] || dmc_request;

	// DMC first, then sprite source on reads, OAM port on writes
	assign dma_addr = dmc_ack    ? dmc_addr     :
	                  !odd_cycle ? src_ptr.flat : nes_dma_pkg::oam_data_addr;

endmodule

`default_nettype wire

/* hw/nes_dma_pkg.sv */
// Shared bus widths, register addresses and the address word type.
// Windows are half-open: base included, end excluded.
`default_nettype none

package nes_dma_pkg;

	localparam int addr_w = 16; // CPU address bus
	localparam int data_w = 8;  // CPU data bus

	localparam logic [addr_w-1:0] oam_data_addr   = 16'h2004; // OAM data port, DMA write target
	localparam logic [addr_w-1:0] oam_dma_addr    = 16'h4014; // Sprite DMA trigger
	localparam logic [addr_w-1:0] apu_status_addr = 16'h4015; // Only readable APU register

	localparam logic [addr_w-1:0] ppu_base = 16'h2000;
	localparam logic [addr_w-1:0] ppu_end  = 16'h4000;
	localparam logic [addr_w-1:0] apu_base = 16'h4000;
	localparam logic [addr_w-1:0] apu_end  = 16'h4018;

	// Same 16 bits, read flat or as page above offset
	typedef union packed {
		logic [addr_w-1:0] flat;
		struct packed {
			logic [data_w-1:0] page;
			logic [data_w-1:0] offset;
		} po;
	} bus_addr_u;

	localparam int div_cpu_default = 12; // Master clocks per CPU cycle

endpackage

`default_nettype wire

/* hw/nes_dma_top.sv */
// OAM and DMC bus-master path, CPU, APU, PPU and memory sit outside.
// Inputs are sampled on the clock where cpu_ce is high.
// Park cpu_addr in the PPU or APU window with cpu_rnw high to keep the memory port quiet.
`timescale 1ns/1ns
`default_nettype none

module nes_dma_top #(
	parameter int DIV_CPU = nes_dma_pkg::div_cpu_default
) (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [nes_dma_pkg::addr_w-1:0] cpu_addr,
	input  logic                           cpu_rnw,
	input  logic [nes_dma_pkg::data_w-1:0] cpu_dout,
	input  logic                           dmc_request,
	input  logic [nes_dma_pkg::addr_w-1:0] dmc_addr,
	input  logic [nes_dma_pkg::data_w-1:0] mem_din,
	input  logic [nes_dma_pkg::data_w-1:0] ppu_din,
	input  logic [nes_dma_pkg::data_w-1:0] apu_din,
	output logic                           cpu_ce,
	output logic [nes_dma_pkg::data_w-1:0] cpu_din,
	output logic                           pause_cpu,
	output logic                           dmc_ack,
	output logic [nes_dma_pkg::addr_w-1:0] mem_addr,
	output logic                           mem_read,
	output logic                           mem_write,
	output logic [nes_dma_pkg::data_w-1:0] mem_wdata
);

	logic                           odd_cycle;
	logic                           sprite_trigger;
	logic [nes_dma_pkg::data_w-1:0] sprite_page;
	logic                           ppu_sel;
	logic                           apu_sel;
	logic                           status_sel;
	logic                           dma_own;
	logic [nes_dma_pkg::addr_w-1:0] dma_addr;
	logic                           dma_read;
	logic [nes_dma_pkg::data_w-1:0] dma_data;
	logic [nes_dma_pkg::data_w-1:0] mem_rdata; // Bus value fed back to the DMA latch

	cpu_cycle_gen #(.DIV_CPU(DIV_CPU)) cycle0 (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.odd_cycle (odd_cycle)
	);

	cpu_bus_decode decode0 (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.cpu_addr       (cpu_addr),
		.cpu_rnw        (cpu_rnw),
		.cpu_dout       (cpu_dout),
		.sprite_trigger (sprite_trigger),
		.sprite_page    (sprite_page),
		.ppu_sel        (ppu_sel),
		.apu_sel        (apu_sel),
		.status_sel     (status_sel)
	);

	dma_sequencer dma0 (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.odd_cycle      (odd_cycle),
		.cpu_rnw        (cpu_rnw),
		.sprite_trigger (sprite_trigger),
		.sprite_page    (sprite_page),
		.dmc_request    (dmc_request),
		.dmc_addr       (dmc_addr),
		.mem_rdata      (mem_rdata),
		.dma_own        (dma_own),
		.dma_addr       (dma_addr),
		.dma_read       (dma_read),
		.dma_data       (dma_data),
		.dmc_ack        (dmc_ack),
		.pause_cpu      (pause_cpu)
	);

	bus_arbiter arb0 (
		.clk        (clk),
		.reset      (reset),
		.cpu_addr   (cpu_addr),
		.cpu_rnw    (cpu_rnw),
		.cpu_dout   (cpu_dout),
		.dma_own    (dma_own),
		.dma_addr   (dma_addr),
		.dma_read   (dma_read),
		.dma_data   (dma_data),
		.ppu_sel    (ppu_sel),
		.apu_sel    (apu_sel),
		.status_sel (status_sel),
		.mem_din    (mem_din),
		.ppu_din    (ppu_din),
		.apu_din    (apu_din),
		.mem_addr   (mem_addr),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.cpu_din    (cpu_din)
	);

endmodule

`default_nettype wire

/* nes_dma.f */
hw/nes_dma_pkg.sv
hw/cpu_cycle_gen.sv
hw/cpu_bus_decode.sv
hw/dma_sequencer.sv
hw/bus_arbiter.sv
hw/nes_dma_top.sv
dv/nes_dma_checker.sv
dv/nes_dma_tb.sv
